/* test/memCtrlVectors.txt */
# op len addr data exp2
# op F fetch, L load, S store, B load and fetch requested together
# data is the expected word, or the store word for S; exp2 is the fetch word for B
F 4 00000010 88817a73 00000000
F 4 000000fc fcf5eee7 00000000
L 1 00000021 000000ea 00000000
L 2 00000040 0000cac3 00000000
L 4 00000080 98918a83 00000000
L 2 00000003 00001f18 00000000
S 1 00000030 123456a5 00000000
L 4 00000030 68615aa5 00000000
S 2 00000050 1234beef 00000000
L 4 00000050 4841beef 00000000
S 4 00000060 cafef00d 00000000
L 4 00000060 cafef00d 00000000
B 2 00000090 0000faf3 0801faf3
B 1 000000c8 0000007b 9089827b
B 4 00000060 cafef00d cafef00d

/* build.f */
source/memCtrlPkg.sv
source/accessSequencer.sv
source/busDriver.sv
source/byteAssembler.sv
source/memCtrl.sv
test/memCtrl_chk.sv
test/memCtrlTb.sv

/* Makefile */
SIM := obj_dir/VmemCtrlTb
SRCS := $(wildcard source/*.sv test/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --assert -f build.f --top-module memCtrlTb

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

/* test/memCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrlTb;
    import memCtrlPkg::*;

    logic              clk;
    logic              rst;
    logic              fetchReq;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchDone;
    logic [WORD_W-1:0] fetchInst;
    dataReq_t          dataReq;
    logic              dataDone;
    logic [WORD_W-1:0] dataRdata;
    owner_t            owner;
    logic [ADDR_W-1:0] memAddr;
    logic              memWrite;
    logic [BYTE_W-1:0] memWdata;
    logic [BYTE_W-1:0] memRdata;

    logic [BYTE_W-1:0] ram [0:255];
    int                errCount;
    int                testCount;
    int                failCount;
    bit                timedOut;
    logic [31:0]       rngState;
    int                waitLimit = 16;

    memCtrl memCtrl_i (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataReq   (dataReq),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .owner     (owner),
        .memAddr   (memAddr),
        .memWrite  (memWrite),
        .memWdata  (memWdata),
        .memRdata  (memRdata)
    );

    always #50 clk = ~clk;

    // ram model with combinational read
    assign memRdata = ram[memAddr[7:0]];

    always @(posedge clk) begin
        if (memWrite) begin
            ram[memAddr[7:0]] <= memWdata;
        end
    end

    function automatic logic [31:0] xorshiftNext(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic accessLen_t lenCode(input int bytes);
        case (bytes)
            1:       return LEN_BYTE;
            2:       return LEN_HALF;
            default: return LEN_WORD;
        endcase
    endfunction

    // data runs in cycles 0..len-1 and a fetch takes four
    function automatic owner_t expectedOwner(input bit useData, input int dataBytes,
                                             input bit useFetch, input int fetchStart,
                                             input int cyc);
        if (useData && cyc < dataBytes) begin
            return OWN_DATA;
        end
        if (useFetch && cyc >= fetchStart && cyc < fetchStart + 4) begin
            return OWN_FETCH;
        end
        return OWN_NONE;
    endfunction

    task automatic checkWord(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkAddr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR memAddr: got %h, expected %h", got, exp);
            errCount++;
        end
    endtask

    task automatic checkOwner(input owner_t got, input owner_t exp);
        if (got !== exp) begin
            $display("ERR owner: got %h, expected %h", got, exp);
            errCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("%s came %0d cycles after the request was taken instead of %0d",
                     name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkIdleNow();
        checkOwner(owner, OWN_NONE);
        checkFlag("fetchDone", fetchDone, 1'b0);
        checkFlag("dataDone", dataDone, 1'b0);
        checkFlag("memWrite", memWrite, 1'b0);
    endtask

    // owner, write strobe and byte address in one cycle of an access
    task automatic checkBusCycle(input bit useData, input int dataBytes, input bit useFetch,
                                 input int fetchStart, input bit isStore,
                                 input logic [ADDR_W-1:0] base, input int cyc);
        owner_t expOwn;
        int     offset;
        expOwn = expectedOwner(useData, dataBytes, useFetch, fetchStart, cyc);
        offset = (expOwn == OWN_FETCH) ? cyc - fetchStart : cyc;
        checkOwner(owner, expOwn);
        checkFlag("memWrite", memWrite, (expOwn == OWN_DATA) && isStore);
        if (expOwn != OWN_NONE) begin
            checkAddr(memAddr, base + ADDR_W'(offset));
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            checkIdleNow();
        end
    endtask

    task automatic runAccess(input byte op, input int len, input logic [ADDR_W-1:0] addr,
                             input logic [WORD_W-1:0] data, input logic [WORD_W-1:0] exp2);
        bit                useData;
        bit                useFetch;
        bit                isStore;
        bit                dataSeen;
        bit                fetchSeen;
        int                fetchStart;
        int                cyc;
        logic [WORD_W-1:0] fetchExp;

        useData = (op != "F");
        useFetch = (op == "F") || (op == "B");
        isStore = (op == "S");
        fetchStart = useData ? len + 1 : 0;
        fetchExp = (op == "B") ? exp2 : data;
        dataSeen = !useData;
        fetchSeen = !useFetch;
        cyc = 0;

        if (useData) begin
            dataReq.en = 1'b1;
            dataReq.store = isStore;
            dataReq.len = lenCode(len);
            dataReq.addr = addr;
            dataReq.wdata = isStore ? data : '0;
        end
        if (useFetch) begin
            fetchReq = 1'b1;
            fetchAddr = addr;
        end

        // the request is taken at the end of cycle 0
        @(negedge clk);
        checkBusCycle(useData, len, useFetch, fetchStart, isStore, addr, 0);
        while (!(dataSeen && fetchSeen) && !timedOut) begin
            @(posedge clk);
            #1;
            cyc++;
            checkBusCycle(useData, len, useFetch, fetchStart, isStore, addr, cyc);
            if (dataDone) begin
                if (dataSeen) begin
                    $display("dataDone pulsed with no data request waiting");
                    errCount++;
                end else begin
                    checkLatency("dataDone", cyc, len);
                    if (!isStore) begin
                        checkWord("dataRdata", dataRdata, data);
                    end
                    dataReq.en = 1'b0;
                    dataSeen = 1'b1;
                end
            end
            if (fetchDone) begin
                if (fetchSeen) begin
                    $display("fetchDone pulsed with no fetch request waiting");
                    errCount++;
                end else begin
                    checkLatency("fetchDone", cyc - fetchStart, 4);
                    checkWord("fetchInst", fetchInst, fetchExp);
                    fetchReq = 1'b0;
                    fetchSeen = 1'b1;
                end
            end
            if (cyc >= waitLimit && !(dataSeen && fetchSeen)) begin
                $display("timeout, no done pulse within %0d cycles", waitLimit);
                errCount++;
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic reportTest(input string label, input int errBefore);
        testCount++;
        if (errCount > errBefore) begin
            failCount++;
            $display("test %0d %s: FAILED", testCount, label);
        end else begin
            $display("test %0d %s: ok", testCount, label);
        end
    endtask

    initial begin
        int                fd;
        int                n;
        int                len;
        int                gap;
        int                errBefore;
        string             line;
        byte               op;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
        logic [WORD_W-1:0] exp2;

        clk = 1'b0;
        rst = 1'b1;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = '0;
        errCount = 0;
        testCount = 0;
        failCount = 0;
        timedOut = 1'b0;
        rngState = 32'd10;
        for (int i = 0; i < 256; i++) begin
            ram[i] = 8'((i * 7 + 3) % 256);
        end

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        errBefore = errCount;
        checkIdleNow();
        idleCycles(2);
        reportTest("after reset", errBefore);

        fd = $fopen("test/memCtrlVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            errCount++;
        end else begin
            while (!timedOut && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                errBefore = errCount;
                n = $sscanf(line, "%c %d %h %h %h", op, len, addr, data, exp2);
                if (n != 5) begin
                    $display("vector line could not be read: %s", line);
                    errCount++;
                end else begin
                    runAccess(op, len, addr, data, exp2);
                    if (!timedOut) begin
                        // random idle gap of at least one cycle
                        rngState = xorshiftNext(rngState);
                        gap = int'(rngState % 32'd4);
                        idleCycles(gap + 1);
                    end
                end
                reportTest($sformatf("%c len %0d addr %h", op, len, addr), errBefore);
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d failed, %0d errors", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/memCtrl_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrl_chk (
    input logic                clk,
    input logic                rst,
    input logic                memWrite,
    input memCtrlPkg::owner_t  owner,
    input logic                fetchDone,
    input logic                dataDone
);
    import memCtrlPkg::*;

    // only a data store may write the ram
    writeByData: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> owner == OWN_DATA)
        else $error("memWrite high while owner is %0d", owner);

    fetchDoneOnce: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetchDone held longer than one cycle");

    dataDoneOnce: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else $error("dataDone held longer than one cycle");

    // one transaction at a time
    donesApart: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone))
        else $error("fetchDone and dataDone in the same cycle");

endmodule

bind memCtrl memCtrl_chk chk_i (
    .clk       (clk),
    .rst       (rst),
    .memWrite  (memWrite),
    .owner     (owner),
    .fetchDone (fetchDone),
    .dataDone  (dataDone)
);

`default_nettype wire

/* source/memCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fetchReq,
    input  logic [memCtrlPkg::ADDR_W-1:0]     fetchAddr,
    output logic                              fetchDone,
    output logic [memCtrlPkg::WORD_W-1:0]     fetchInst,
    input  memCtrlPkg::dataReq_t              dataReq,
    output logic                              dataDone,
    output logic [memCtrlPkg::WORD_W-1:0]     dataRdata,
    output memCtrlPkg::owner_t                owner,
    output logic [memCtrlPkg::ADDR_W-1:0]     memAddr,
    output logic                              memWrite,
    output logic [memCtrlPkg::BYTE_W-1:0]     memWdata,
    input  logic [memCtrlPkg::BYTE_W-1:0]     memRdata
);
    import memCtrlPkg::*;

    busCmd_t busCmd;

    accessSequencer accessSequencer_i (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .dataEn    (dataReq.en),
        .dataStore (dataReq.store),
        .dataLen   (dataReq.len),
        .busCmd    (busCmd),
        .fetchDone (fetchDone),
        .dataDone  (dataDone),
        .owner     (owner)
    );

    busDriver busDriver_i (
        .clk       (clk),
        .rst       (rst),
        .busCmd    (busCmd),
        .fetchAddr (fetchAddr),
        .dataAddr  (dataReq.addr),
        .dataWdata (dataReq.wdata),
        .memAddr   (memAddr),
        .memWrite  (memWrite),
        .memWdata  (memWdata)
    );

    byteAssembler byteAssembler_i (
        .clk       (clk),
        .rst       (rst),
        .busCmd    (busCmd),
        .dataLen   (dataReq.len),
        .memRdata  (memRdata),
        .fetchInst (fetchInst),
        .dataRdata (dataRdata)
    );

endmodule

`default_nettype wire

/* source/byteAssembler.sv */
`timescale 1ns/1ps
`default_nettype none

module byteAssembler (
    input  logic                              clk,
    input  logic                              rst,
    input  memCtrlPkg::busCmd_t               busCmd,
    input  memCtrlPkg::accessLen_t            dataLen,
    input  logic [memCtrlPkg::BYTE_W-1:0]     memRdata,
    output logic [memCtrlPkg::WORD_W-1:0]     fetchInst,
    output logic [memCtrlPkg::WORD_W-1:0]     dataRdata
);
    import memCtrlPkg::*;

    logic [WORD_W-1:0] asmWord;
    logic [WORD_W-1:0] merged;
    logic [WORD_W-1:0] loadMask;
    logic              capture;

    assign capture = (busCmd.owner != OWN_NONE) && !busCmd.write;

    // word as it stands once the current byte is in
    always_comb begin
        merged = asmWord;
        merged[busCmd.byteIdx*BYTE_W +: BYTE_W] = memRdata;
    end

    always_comb begin
        case (dataLen)
            LEN_BYTE: loadMask = 32'h0000_00ff;
            LEN_HALF: loadMask = 32'h0000_ffff;
            default:  loadMask = 32'hffff_ffff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            asmWord <= '0;
        end else if (capture) begin
            if (busCmd.last) begin
                asmWord <= '0;
            end else begin
                asmWord <= merged;
            end
        end
    end

    // results hold until the same requester finishes again
    always_ff @(posedge clk) begin
        if (capture && busCmd.last) begin
            if (busCmd.owner == OWN_FETCH) begin
                fetchInst <= merged;
            end else begin
                dataRdata <= merged & loadMask;
            end
        end
    end

endmodule

`default_nettype wire

/* source/busDriver.sv */
`timescale 1ns/1ps
`default_nettype none

module busDriver (
    input  logic                              clk,
    input  logic                              rst,
    input  memCtrlPkg::busCmd_t               busCmd,
    input  logic [memCtrlPkg::ADDR_W-1:0]     fetchAddr,
    input  logic [memCtrlPkg::ADDR_W-1:0]     dataAddr,
    input  logic [memCtrlPkg::WORD_W-1:0]     dataWdata,
    output logic [memCtrlPkg::ADDR_W-1:0]     memAddr,
    output logic                              memWrite,
    output logic [memCtrlPkg::BYTE_W-1:0]     memWdata
);
    import memCtrlPkg::*;

    logic [ADDR_W-1:0] baseAddr;
    logic [ADDR_W-1:0] reqAddr;
    logic [ADDR_W-1:0] curBase;
    logic [WORD_W-1:0] storeWord;
    logic [WORD_W-1:0] curWord;

    assign reqAddr = (busCmd.owner == OWN_DATA) ? dataAddr : fetchAddr;

    // latched copies are not there yet in the start cycle
    assign curBase = busCmd.start ? reqAddr : baseAddr;
    assign curWord = busCmd.start ? dataWdata : storeWord;

    assign memAddr  = curBase + ADDR_W'(busCmd.byteIdx);
    assign memWrite = busCmd.write;

    // little-endian, byte k of the word goes to base plus k
    assign memWdata = busCmd.write ? curWord[busCmd.byteIdx*BYTE_W +: BYTE_W] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseAddr <= '0;
        end else if (busCmd.start) begin
            baseAddr <= reqAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (busCmd.start) begin
            storeWord <= dataWdata;
        end
    end

endmodule

`default_nettype wire

/* source/accessSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module accessSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchReq,
    input  logic                   dataEn,
    input  logic                   dataStore,
    input  memCtrlPkg::accessLen_t dataLen,
    output memCtrlPkg::busCmd_t    busCmd,
    output logic                   fetchDone,
    output logic                   dataDone,
    output memCtrlPkg::owner_t     owner
);
    import memCtrlPkg::*;

    logic       busy;
    owner_t     curOwner;
    logic [1:0] byteIdx;
    logic [1:0] lastIdx;
    logic       curWrite;
    logic       idle;
    owner_t     grant;
    logic [1:0] grantLast;

    // the done cycle still counts as busy, requests are looked at one cycle later
    assign idle = !busy && !fetchDone && !dataDone;

    // data first when both are waiting
    always_comb begin
        if (dataEn) begin
            grant     = OWN_DATA;
            grantLast = dataLen;
        end else if (fetchReq) begin
            grant     = OWN_FETCH;
            grantLast = 2'(FETCH_BYTES - 1);
        end else begin
            grant     = OWN_NONE;
            grantLast = 2'd0;
        end
    end

    always_comb begin
        busCmd       = '0;
        busCmd.owner = OWN_NONE;
        if (busy) begin
            busCmd.owner   = curOwner;
            busCmd.byteIdx = byteIdx;
            busCmd.write   = curWrite;
            busCmd.last    = (byteIdx == lastIdx);
        end else if (idle && grant != OWN_NONE) begin
            // first byte goes out in the same cycle the request is taken
            busCmd.start = 1'b1;
            busCmd.owner = grant;
            busCmd.write = (grant == OWN_DATA) && dataStore;
            busCmd.last  = (grantLast == 2'd0);
        end
    end

    assign owner = busCmd.owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
            curOwner  <= OWN_NONE;
            byteIdx   <= 2'd0;
            lastIdx   <= 2'd0;
            curWrite  <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
            if (busCmd.start) begin
                curOwner <= grant;
                lastIdx  <= grantLast;
                curWrite <= busCmd.write;
            end
            if (busCmd.owner != OWN_NONE) begin
                if (busCmd.last) begin
                    busy      <= 1'b0;
                    byteIdx   <= 2'd0;
                    fetchDone <= (busCmd.owner == OWN_FETCH);
                    dataDone  <= (busCmd.owner == OWN_DATA);
                end else begin
                    busy    <= 1'b1;
                    byteIdx <= busCmd.byteIdx + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/memCtrlPkg.sv */
`default_nettype none

package memCtrlPkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;

    // a fetch always reads a full word
    localparam int FETCH_BYTES = 4;

    // encoded as byte count minus one, so the value is the last byte index
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd3
    } accessLen_t;

    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0,
        OWN_DATA  = 2'd1,
        OWN_FETCH = 2'd2
    } owner_t;

    typedef struct packed {
        logic              en;
        logic              store;
        accessLen_t        len;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } dataReq_t;

    // one byte step of a transaction
    typedef struct packed {
        logic       start;
        owner_t     owner;
        logic [1:0] byteIdx;
        logic       write;
        logic       last;
    } busCmd_t;

endpackage

`default_nettype wire
